// ==== game_pkg.sv ====
package game_pkg;

  localparam int CANVAS_WIDTH = 1280;  // display size in pixels
  localparam int CANVAS_HEIGHT = 720;
  localparam int NUM_FRAMES = 32;      // animation frames in the sheet
  localparam int INSTR_W = 36;
  localparam int NUM_REGS = 32;
  localparam int FIELDS_PER_SPRITE = 8;

  typedef logic [31:0] word_t;  // register value
  typedef logic [INSTR_W-1:0] instr_t;
  typedef logic [12:0] field_t;  // one sprite attribute
  typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;
  typedef logic [5:0] slot_idx_t;
  typedef logic [$clog2(FIELDS_PER_SPRITE)-1:0] field_idx_t;
  typedef logic [7:0] pc_t;  // instruction address
  typedef logic [$clog2(CANVAS_WIDTH)-1:0] x_t;
  typedef logic [$clog2(CANVAS_HEIGHT)-1:0] y_t;
  typedef logic [$clog2(NUM_FRAMES)-1:0] frame_id_t;

  localparam field_idx_t FLD_KIND = 3'd0;  // slot exists when nonzero
  localparam field_idx_t FLD_X = 3'd1;
  localparam field_idx_t FLD_Y = 3'd2;
  localparam field_idx_t FLD_FRAME = 3'd3;

  // field 0 in the low bits, so field n sits at [n*13 +: 13]
  typedef struct packed {
    field_t f7;
    field_t f6;
    field_t f5;
    field_t f4;
    field_t frame;
    field_t y;
    field_t x;
    field_t kind;
  } sprite_rec_t;

  typedef struct packed {
    logic       we;     // one-cycle strobe
    slot_idx_t  slot;
    field_idx_t field;
    field_t     data;
  } sprite_wr_t;

  typedef logic [7:0] opkey_t;  // {instr[32], instr[6:0]}
  localparam opkey_t OPK_LI = 8'b0011_0111;
  localparam opkey_t OPK_REGIMM = 8'b0001_0011;
  localparam opkey_t OPK_REGREG = 8'b0011_0011;
  localparam opkey_t OPK_BRANCH = 8'b0110_0011;
  localparam opkey_t OPK_JMP = 8'b0110_0001;
  localparam opkey_t OPK_SPLI = 8'b1011_0111;
  localparam opkey_t OPK_SPLREG = 8'b1000_0001;
  localparam opkey_t OPK_LISP = 8'b1011_1111;
  localparam opkey_t OPK_DIST = 8'b1111_1111;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUBF, ALU_SLL, ALU_SRL, ALU_ABSD, ALU_DIST, ALU_PASS
  } alu_op_t;

  // funct3 of the branch group
  typedef enum logic [2:0] {
    BR_EQ = 3'd0, BR_NE = 3'd1, BR_LT = 3'd4, BR_GE = 3'd5
  } br_op_t;

  typedef enum logic [2:0] {
    ST_FETCH, ST_DECODE, ST_EXECUTE, ST_WRITEBACK, ST_HALT
  } core_state_t;

endpackage

// ==== instr_mem.sv ====
module instr_mem #(
  parameter int INSTR_DEPTH = 256
) (
  input  logic             pixel_clk_in,
  input  logic             we,     // load port
  input  game_pkg::pc_t    waddr,
  input  game_pkg::instr_t wdata,
  input  game_pkg::pc_t    raddr,  // core fetch port
  output game_pkg::instr_t rdata
);
  game_pkg::instr_t mem [INSTR_DEPTH];  // one word per instruction slot

  always_ff @(posedge pixel_clk_in) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];  // read first on a same-address write
  end

endmodule

// ==== sprite_table.sv ====
module sprite_table #(
  parameter int NUM_SPRITES = 64
) (
  input  logic                  pixel_clk_in,
  input  logic                  rst_in,
  input  game_pkg::sprite_wr_t  wr,         // single field write from the core
  input  game_pkg::slot_idx_t   slot_a,
  input  game_pkg::slot_idx_t   slot_b,
  input  game_pkg::slot_idx_t   slot_scan,
  output game_pkg::sprite_rec_t rec_a,      // lisp / dist operands
  output game_pkg::sprite_rec_t rec_b,
  output game_pkg::sprite_rec_t rec_scan    // video side
);
  localparam int FW = $bits(game_pkg::field_t);

  game_pkg::sprite_rec_t recs [NUM_SPRITES];

  // flat clear of every kind, the other fields keep old contents
  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < NUM_SPRITES; i++) begin
        recs[i].kind <= '0;
      end
    end else if (wr.we) begin
      recs[wr.slot][wr.field*FW +: FW] <= wr.data;  // replace one field only
    end
  end

  // three registered read ports
  // a write to the same slot this cycle shows up one read later
  always_ff @(posedge pixel_clk_in) begin
    rec_a <= recs[slot_a];
    rec_b <= recs[slot_b];
    rec_scan <= recs[slot_scan];
  end

endmodule

// ==== game_alu.sv ====
module game_alu (
  input  game_pkg::alu_op_t op,
  input  game_pkg::word_t   a,
  input  game_pkg::word_t   b,
  input  game_pkg::word_t   c,      // second pair, dist only
  input  game_pkg::word_t   d,
  output game_pkg::word_t   result
);
  game_pkg::word_t diff_ab;
  game_pkg::word_t diff_cd;

  // unsigned distance, never wraps
  function automatic game_pkg::word_t abs_diff(game_pkg::word_t p, game_pkg::word_t q);
    return (p >= q) ? p - q : q - p;
  endfunction

  assign diff_ab = abs_diff(a, b);
  assign diff_cd = abs_diff(c, d);

  always_comb begin
    case (op)
      game_pkg::ALU_ADD:  result = a + b;
      game_pkg::ALU_SUBF: result = (a >= b) ? a - b : '0;  // floored at zero
      game_pkg::ALU_SLL:  result = a << b;  // shift of 32 or more gives 0
      game_pkg::ALU_SRL:  result = a >> b;
      game_pkg::ALU_ABSD: result = diff_ab;
      game_pkg::ALU_DIST: result = diff_ab + diff_cd;  // manhattan over two fields
      default:            result = a;  // pass, li / spli / splreg / lisp
    endcase
  end

endmodule

// ==== game_core.sv ====
module game_core #(
  parameter int INSTR_DEPTH = 256  // pc at or past this halts
) (
  input  logic                  pixel_clk_in,
  input  logic                  rst_in,
  input  logic                  restart,     // load write to address 0
  output game_pkg::pc_t         fetch_addr,
  input  game_pkg::instr_t      instr,       // valid from decode until next fetch
  output game_pkg::slot_idx_t   rd_slot_a,
  output game_pkg::slot_idx_t   rd_slot_b,
  input  game_pkg::sprite_rec_t rec_a,       // arrives in execute
  input  game_pkg::sprite_rec_t rec_b,
  output game_pkg::sprite_wr_t  sprite_wr,
  output logic                  halted
);
  localparam int FW = $bits(game_pkg::field_t);

  game_pkg::core_state_t state_q;
  game_pkg::word_t regs [game_pkg::NUM_REGS];
  game_pkg::word_t pc_q;  // full word so running off the end does not wrap
  game_pkg::word_t res_q;
  game_pkg::opkey_t key;
  game_pkg::word_t rs1_val;
  game_pkg::word_t rs2_val;
  game_pkg::word_t rd_val;
  game_pkg::alu_op_t op;
  game_pkg::word_t opnd_a;
  game_pkg::word_t opnd_b;
  game_pkg::word_t target;
  game_pkg::word_t alu_res;
  game_pkg::slot_idx_t wslot;
  logic known;
  logic taken;
  logic wr_reg;
  logic wr_spr;

  function automatic game_pkg::word_t get_field(game_pkg::sprite_rec_t rec,
                                                game_pkg::field_idx_t idx);
    return game_pkg::word_t'(rec[idx*FW +: FW]);
  endfunction

  assign key = {instr[32], instr[6:0]};
  assign rs1_val = regs[instr[19:15]];
  assign rs2_val = regs[instr[24:20]];
  assign rd_val = regs[instr[11:7]];
  assign rd_slot_a = game_pkg::slot_idx_t'(rs1_val);  // read in decode, used in execute
  assign rd_slot_b = game_pkg::slot_idx_t'(rs2_val);
  assign fetch_addr = game_pkg::pc_t'(pc_q);
  assign halted = state_q == game_pkg::ST_HALT;

  // decode straight off instr, regs only change at writeback
  always_comb begin
    op = game_pkg::ALU_PASS;
    opnd_a = rs1_val;
    opnd_b = game_pkg::word_t'(instr[31:20]);  // i-immediate, zero extended
    target = game_pkg::word_t'({instr[31:25], instr[11:7]});
    wslot = game_pkg::slot_idx_t'(rd_val);     // spli slot is regs[rd]
    known = 1'b1;
    taken = 1'b0;
    wr_reg = 1'b0;
    wr_spr = 1'b0;
    case (key)
      game_pkg::OPK_LI: begin
        opnd_a = game_pkg::word_t'(instr[31:12]);  // u-immediate, not shifted
        wr_reg = 1'b1;
      end
      game_pkg::OPK_REGIMM: begin
        wr_reg = 1'b1;
        case (instr[14:12])
          3'd0: op = game_pkg::ALU_ADD;
          3'd1: op = game_pkg::ALU_SUBF;
          3'd2: op = game_pkg::ALU_SLL;
          3'd5: op = game_pkg::ALU_SRL;
          default: wr_reg = 1'b0;  // unused sub-op, no effect
        endcase
      end
      game_pkg::OPK_REGREG: begin
        opnd_b = rs2_val;
        wr_reg = 1'b1;
        case (instr[31:25])
          7'd0: op = game_pkg::ALU_ADD;
          7'd1: op = game_pkg::ALU_SUBF;
          7'd2: op = game_pkg::ALU_SLL;
          7'd4: op = game_pkg::ALU_SRL;
          7'd5: op = game_pkg::ALU_ABSD;
          default: wr_reg = 1'b0;
        endcase
      end
      game_pkg::OPK_BRANCH: begin
        case (game_pkg::br_op_t'(instr[14:12]))  // regs[24:20] vs regs[19:15], unsigned
          game_pkg::BR_EQ: taken = rs2_val == rs1_val;
          game_pkg::BR_NE: taken = rs2_val != rs1_val;
          game_pkg::BR_LT: taken = rs2_val < rs1_val;
          game_pkg::BR_GE: taken = rs2_val >= rs1_val;
          default: taken = 1'b0;
        endcase
      end
      game_pkg::OPK_JMP: begin
        taken = 1'b1;
        target = game_pkg::word_t'(instr[31:7]);
      end
      game_pkg::OPK_SPLI: begin
        opnd_a = game_pkg::word_t'(instr[31:12]);
        wr_spr = 1'b1;
      end
      game_pkg::OPK_SPLREG: begin
        opnd_a = rd_val;  // data from regs[rd]
        wslot = game_pkg::slot_idx_t'(regs[instr[16:12]]);
        wr_spr = 1'b1;
      end
      game_pkg::OPK_LISP: begin
        opnd_a = get_field(rec_a, instr[35:33]);
        wr_reg = 1'b1;
      end
      game_pkg::OPK_DIST: begin
        op = game_pkg::ALU_DIST;
        opnd_a = get_field(rec_a, instr[35:33]);
        opnd_b = get_field(rec_b, instr[35:33]);
        wr_reg = 1'b1;
      end
      default: known = 1'b0;  // includes empty slots
    endcase
  end

  game_alu alu_i (
    .op(op), .a(opnd_a), .b(opnd_b),
    .c(get_field(rec_a, instr[31:29])),  // dist second field
    .d(get_field(rec_b, instr[31:29])),
    .result(alu_res)
  );

  assign sprite_wr.we = (state_q == game_pkg::ST_WRITEBACK) && wr_spr;
  assign sprite_wr.slot = wslot;
  assign sprite_wr.field = instr[35:33];
  assign sprite_wr.data = game_pkg::field_t'(res_q);  // low 13 bits

  always_ff @(posedge pixel_clk_in) begin
    if (state_q == game_pkg::ST_WRITEBACK && wr_reg) begin
      regs[instr[11:7]] <= res_q;  // x0 is writable too
    end
  end

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in || restart) begin
      state_q <= game_pkg::ST_FETCH;
      pc_q <= '0;
    end else begin
      case (state_q)
        game_pkg::ST_FETCH: state_q <= game_pkg::ST_DECODE;  // memory reads pc here
        game_pkg::ST_DECODE: begin
          if (!known || pc_q >= INSTR_DEPTH) begin
            state_q <= game_pkg::ST_HALT;
          end else begin
            state_q <= game_pkg::ST_EXECUTE;
          end
        end
        game_pkg::ST_EXECUTE: begin
          res_q <= alu_res;
          state_q <= game_pkg::ST_WRITEBACK;
        end
        game_pkg::ST_WRITEBACK: begin
          pc_q <= taken ? target : pc_q + 32'd1;
          state_q <= game_pkg::ST_FETCH;
        end
        default: state_q <= game_pkg::ST_HALT;  // parked until reset or restart
      endcase
    end
  end

endmodule

// ==== sprite_scanner.sv ====
module sprite_scanner #(
  parameter int NUM_SPRITES = 64,
  parameter int SLOT_CYCLES = 2500  // dwell per slot
) (
  input  logic                  pixel_clk_in,
  input  logic                  rst_in,
  input  logic                  new_frame,
  output game_pkg::slot_idx_t   scan_slot,
  input  game_pkg::sprite_rec_t rec,         // one cycle behind scan_slot
  output game_pkg::x_t          x,
  output game_pkg::y_t          y,
  output game_pkg::frame_id_t   frame,
  output logic                  sprite_valid
);
  localparam int DWELL_W = $clog2(SLOT_CYCLES + 1);

  logic [DWELL_W-1:0] dwell_q;
  logic active_q;  // walking the slots
  logic live_q;    // active, lined up with rec
  logic slot_done;

  assign slot_done = dwell_q == DWELL_W'(SLOT_CYCLES - 1);

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      active_q <= 1'b0;
      live_q <= 1'b0;
      sprite_valid <= 1'b0;
      scan_slot <= '0;
      dwell_q <= '0;
    end else begin
      live_q <= active_q;
      sprite_valid <= live_q && (rec.kind != '0);
      if (new_frame) begin  // also restarts a frame in progress
        active_q <= 1'b1;
        scan_slot <= '0;
        dwell_q <= '0;
      end else if (active_q) begin
        if (slot_done) begin
          dwell_q <= '0;
          if (scan_slot == game_pkg::slot_idx_t'(NUM_SPRITES - 1)) begin
            active_q <= 1'b0;  // idle until next new_frame
          end else begin
            scan_slot <= scan_slot + 1'b1;
          end
        end else begin
          dwell_q <= dwell_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge pixel_clk_in) begin
    x <= game_pkg::x_t'(rec.x);  // low bits of the 13-bit fields
    y <= game_pkg::y_t'(rec.y);
    frame <= game_pkg::frame_id_t'(rec.frame);
  end

endmodule

// ==== game_top.sv ====
module game_top #(
  parameter int INSTR_DEPTH = 256,
  parameter int NUM_SPRITES = 64,
  parameter int SLOT_CYCLES = 2500
) (
  input  logic                pixel_clk_in,
  input  logic                rst_in,
  input  logic                new_frame,
  input  logic                prog_we,
  input  game_pkg::pc_t       prog_addr,
  input  game_pkg::instr_t    prog_data,
  output game_pkg::x_t        x,
  output game_pkg::y_t        y,
  output game_pkg::frame_id_t frame,
  output logic                sprite_valid,
  output logic                halted
);
  game_pkg::pc_t fetch_addr;
  game_pkg::instr_t instr;
  game_pkg::slot_idx_t rd_slot_a;
  game_pkg::slot_idx_t rd_slot_b;
  game_pkg::slot_idx_t scan_slot;
  game_pkg::sprite_rec_t rec_a;
  game_pkg::sprite_rec_t rec_b;
  game_pkg::sprite_rec_t scan_rec;
  game_pkg::sprite_wr_t sprite_wr;
  logic restart;

  assign restart = prog_we && (prog_addr == '0);  // slot 0 write reruns the program

  instr_mem #(.INSTR_DEPTH(INSTR_DEPTH)) instr_mem_i (
    .pixel_clk_in(pixel_clk_in), .we(prog_we), .waddr(prog_addr), .wdata(prog_data),
    .raddr(fetch_addr), .rdata(instr)
  );

  game_core #(.INSTR_DEPTH(INSTR_DEPTH)) core_i (
    .pixel_clk_in(pixel_clk_in), .rst_in(rst_in), .restart(restart),
    .fetch_addr(fetch_addr), .instr(instr),
    .rd_slot_a(rd_slot_a), .rd_slot_b(rd_slot_b), .rec_a(rec_a), .rec_b(rec_b),
    .sprite_wr(sprite_wr), .halted(halted)
  );

  sprite_table #(.NUM_SPRITES(NUM_SPRITES)) sprite_table_i (
    .pixel_clk_in(pixel_clk_in), .rst_in(rst_in), .wr(sprite_wr),
    .slot_a(rd_slot_a), .slot_b(rd_slot_b), .slot_scan(scan_slot),
    .rec_a(rec_a), .rec_b(rec_b), .rec_scan(scan_rec)
  );

  sprite_scanner #(.NUM_SPRITES(NUM_SPRITES), .SLOT_CYCLES(SLOT_CYCLES)) scanner_i (
    .pixel_clk_in(pixel_clk_in), .rst_in(rst_in), .new_frame(new_frame),
    .scan_slot(scan_slot), .rec(scan_rec),
    .x(x), .y(y), .frame(frame), .sprite_valid(sprite_valid)
  );

endmodule

// ==== game_checker.sv ====
module game_checker #(
  parameter int NUM_SPRITES = 64,
  parameter int SLOT_CYCLES = 2500
) (
  input  logic                  pixel_clk_in,
  input  logic                  rst_in,
  input  logic                  new_frame,
  input  logic                  prog_we,
  input  game_pkg::pc_t         prog_addr,
  input  logic                  halted,
  input  game_pkg::x_t          x,
  input  game_pkg::y_t          y,
  input  game_pkg::frame_id_t   frame,
  input  logic                  sprite_valid,
  input  game_pkg::sprite_rec_t exp_tab [NUM_SPRITES],  // model table
  input  int                    exp_count,  // instructions the model ran
  output int                    errors
);
  timeunit 1ns;
  timeprecision 100ps;

  logic run_q;      // a frame has started
  logic kick_q;     // reset or restart seen last edge
  int cnt_q;        // edges since new_frame
  logic busy_q;     // program running since restart
  int run_cyc_q;    // edges since restart

  initial errors = 0;

  always @(posedge pixel_clk_in) begin
    kick_q <= rst_in || (prog_we && prog_addr == '0);
    if (rst_in) begin
      run_q <= 1'b0;
      cnt_q <= 0;
    end else if (new_frame) begin
      run_q <= 1'b1;
      cnt_q <= 0;
    end else if (run_q) begin
      cnt_q <= cnt_q + 1;
    end
  end

  always @(posedge pixel_clk_in) begin
    if (rst_in) begin
      busy_q <= 1'b0;
      run_cyc_q <= 0;
    end else if (prog_we && prog_addr == '0) begin
      busy_q <= 1'b1;
      run_cyc_q <= 0;
    end else if (busy_q) begin
      busy_q <= !halted;  // one look at the rise
      run_cyc_q <= run_cyc_q + 1;
    end
  end

  // sample mid-cycle away from both edges
  always @(negedge pixel_clk_in) begin
    int k;
    logic exp_valid;
    game_pkg::sprite_rec_t r;
    if (!rst_in) begin
      if (kick_q && halted) begin
        errors++;
        $display("error halted exp %h got %h after reset or restart", 1'b0, halted);
      end
      // four cycles per instruction, then fetch and decode of the empty slot
      if (busy_q && halted && run_cyc_q != 4 * exp_count + 2) begin
        errors++;
        $display("error halted rise cycle exp %h got %h", 4 * exp_count + 2, run_cyc_q);
      end
      k = NUM_SPRITES;  // past the last slot unless a window is open
      if (run_q) k = (cnt_q - 2) / SLOT_CYCLES;
      exp_valid = 1'b0;
      r = '0;
      if (k < NUM_SPRITES) begin
        r = exp_tab[k];
        exp_valid = r.kind != '0;
      end
      if (!(run_q && cnt_q < 2)) begin  // first two edges still show the old slot
        if (sprite_valid !== exp_valid) begin
          errors++;
          $display("error sprite_valid slot %0d exp %h got %h", k, exp_valid, sprite_valid);
        end else if (exp_valid) begin
          if (x !== game_pkg::x_t'(r.x)) begin
            errors++;
            $display("error x slot %0d exp %h got %h", k, game_pkg::x_t'(r.x), x);
          end
          if (y !== game_pkg::y_t'(r.y)) begin
            errors++;
            $display("error y slot %0d exp %h got %h", k, game_pkg::y_t'(r.y), y);
          end
          if (frame !== game_pkg::frame_id_t'(r.frame)) begin
            errors++;
            $display("error frame slot %0d exp %h got %h", k,
                     game_pkg::frame_id_t'(r.frame), frame);
          end
        end
      end
    end
  end

endmodule

// ==== tb_game_top.sv ====
module tb_game_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int INSTR_DEPTH = 256;
  localparam int NUM_SPRITES = 64;
  localparam int SLOT_CYCLES = 3;  // short dwell for sim
  localparam int NPROG = 4;
  localparam int PRE = 8;          // li preamble over regs 0..7
  localparam int BODY = 24;
  localparam int LIMIT = NPROG * (4 * INSTR_DEPTH + 2 * NUM_SPRITES * SLOT_CYCLES) + 1000;

  logic pixel_clk_in;
  logic rst_in;
  logic new_frame;
  logic prog_we;
  game_pkg::pc_t prog_addr;
  game_pkg::instr_t prog_data;
  game_pkg::x_t x;
  game_pkg::y_t y;
  game_pkg::frame_id_t frame;
  logic sprite_valid;
  logic halted;
  int chk_errors;
  int n_exec;

  game_pkg::sprite_rec_t exp_tab [NUM_SPRITES];  // model sprite table
  game_pkg::word_t mreg [game_pkg::NUM_REGS];     // model registers
  game_pkg::instr_t prog [PRE+BODY+1];

  always #4 pixel_clk_in = ~pixel_clk_in;

  game_top #(
    .INSTR_DEPTH(INSTR_DEPTH), .NUM_SPRITES(NUM_SPRITES), .SLOT_CYCLES(SLOT_CYCLES)
  ) dut_i (
    .pixel_clk_in(pixel_clk_in), .rst_in(rst_in), .new_frame(new_frame),
    .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
    .x(x), .y(y), .frame(frame), .sprite_valid(sprite_valid), .halted(halted)
  );

  game_checker #(.NUM_SPRITES(NUM_SPRITES), .SLOT_CYCLES(SLOT_CYCLES)) chk_i (
    .pixel_clk_in(pixel_clk_in), .rst_in(rst_in), .new_frame(new_frame),
    .prog_we(prog_we), .prog_addr(prog_addr), .halted(halted),
    .x(x), .y(y), .frame(frame), .sprite_valid(sprite_valid),
    .exp_tab(exp_tab), .exp_count(n_exec), .errors(chk_errors)
  );

  // {field sel, key msb, funct7, rs2, rs1, funct3, rd, opcode}
  function automatic game_pkg::instr_t enc(game_pkg::opkey_t key, logic [2:0] fld,
      logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1, logic [2:0] f3, logic [4:0] rd);
    return {fld, key[7], f7, rs2, rs1, f3, rd, key[6:0]};
  endfunction

  function automatic game_pkg::instr_t enc_u(game_pkg::opkey_t key, logic [2:0] fld,
      logic [4:0] rd, logic [19:0] imm);
    return {fld, key[7], imm, rd, key[6:0]};
  endfunction

  function automatic game_pkg::word_t absd(game_pkg::word_t p, game_pkg::word_t q);
    return (p > q) ? p - q : q - p;
  endfunction

  // 0 add, 1 floored sub, 2 sll, 3 srl, 4 abs difference
  function automatic game_pkg::word_t calc(int code, game_pkg::word_t a, game_pkg::word_t b);
    case (code)
      0: return a + b;
      1: return (a >= b) ? a - b : 32'd0;
      2: return (b >= 32) ? 32'd0 : a << b;
      3: return (b >= 32) ? 32'd0 : a >> b;
      default: return absd(a, b);
    endcase
  endfunction

  function automatic game_pkg::word_t field_of(game_pkg::slot_idx_t s, logic [2:0] f);
    return game_pkg::word_t'(exp_tab[s][int'(f)*13 +: 13]);
  endfunction

  // instruction kinds 0..8 are li ri rr br jmp spli splreg lisp dist
  function automatic int pick_kind(int mode);
    logic [8:0] mask;
    int k;
    case (mode)
      0: mask = 9'b001000111;  // arithmetic into sprites
      1: mask = 9'b001111010;  // branches and jumps
      2: mask = 9'b111100001;  // sprite reads and dist
      default: mask = '1;
    endcase
    do k = $urandom_range(0, 8); while (!mask[k]);
    return k;
  endfunction

  task automatic gen_prog(int mode);
    int pc;
    int sel;
    logic [4:0] rd;
    logic [4:0] r1;
    logic [4:0] r2;
    logic [2:0] f;
    logic [24:0] t;
    logic [11:0] imm;
    for (int r = 0; r < PRE; r++) begin
      // small values on low regs so compares hit equality
      prog[r] = enc_u(game_pkg::OPK_LI, 3'd0, 5'(r),
                      20'((r < 4) ? $urandom_range(0, 3) : $urandom_range(0, 4095)));
    end
    for (int i = 0; i < BODY; i++) begin
      pc = PRE + i;
      rd = 5'($urandom_range(0, 7));
      r1 = 5'($urandom_range(0, 7));
      r2 = 5'($urandom_range(0, 7));
      f = 3'($urandom_range(0, 4));
      t = 25'($urandom_range(pc + 1, PRE + BODY));  // forward only
      sel = $urandom_range(0, 4);
      imm = 12'($urandom_range(0, 35));
      case (pick_kind(mode))
        0: prog[pc] = enc_u(game_pkg::OPK_LI, 3'd0, rd, 20'($urandom_range(0, 2000)));
        1: prog[pc] = enc(game_pkg::OPK_REGIMM, 3'd0, imm[11:5], imm[4:0], r1,
                          3'((sel >= 3) ? 5 : sel), rd);  // imm up to 35 for shifts past 31
        2: prog[pc] = enc(game_pkg::OPK_REGREG, 3'd0, 7'((sel >= 3) ? sel + 1 : sel),
                          r2, r1, 3'd0, rd);
        3: prog[pc] = enc(game_pkg::OPK_BRANCH, 3'd0, t[11:5], r2, r1,
                          3'((sel % 4 >= 2) ? sel % 4 + 2 : sel % 4), t[4:0]);
        4: prog[pc] = enc_u(game_pkg::OPK_JMP, 3'd0, t[4:0], t[24:5]);
        5: prog[pc] = enc_u(game_pkg::OPK_SPLI, f, rd, 20'($urandom));
        6: prog[pc] = enc(game_pkg::OPK_SPLREG, f, 7'd0, 5'd0, {3'd0, r1[4:3]}, r1[2:0], rd);
        7: prog[pc] = enc(game_pkg::OPK_LISP, f, 7'd0, 5'd0, r1, 3'd0, rd);
        default: prog[pc] = enc(game_pkg::OPK_DIST, f, {3'($urandom_range(0, 4)), 4'd0},
                                r2, r1, 3'd0, rd);
      endcase
    end
    prog[PRE+BODY] = '0;  // empty slot halts the core
  endtask

  task automatic run_model(output int count);
    game_pkg::word_t pc;
    game_pkg::word_t nxt;
    game_pkg::instr_t w;
    game_pkg::opkey_t key;
    game_pkg::word_t a;
    game_pkg::word_t b;
    game_pkg::slot_idx_t sa;
    game_pkg::slot_idx_t sb;
    logic [4:0] rd;
    logic done;
    pc = 0;
    count = 0;
    done = 1'b0;
    while (!done) begin
      w = (pc <= PRE + BODY) ? prog[pc] : '0;
      key = {w[32], w[6:0]};
      rd = w[11:7];
      a = mreg[w[19:15]];
      b = mreg[w[24:20]];
      sa = game_pkg::slot_idx_t'(a);
      sb = game_pkg::slot_idx_t'(b);
      nxt = pc + 1;
      count++;
      case (key)
        game_pkg::OPK_LI: mreg[rd] = game_pkg::word_t'(w[31:12]);
        game_pkg::OPK_REGIMM: mreg[rd] = calc((w[14:12] == 3'd5) ? 3 : int'(w[14:12]), a,
                                              game_pkg::word_t'(w[31:20]));
        game_pkg::OPK_REGREG: mreg[rd] = calc((w[31:25] >= 7'd4) ? int'(w[31:25]) - 1
                                              : int'(w[31:25]), a, b);
        game_pkg::OPK_BRANCH: begin
          // rs2 compared unsigned against rs1
          if ((w[14:12] == 3'd0 && b == a) || (w[14:12] == 3'd1 && b != a) ||
              (w[14:12] == 3'd4 && b < a) || (w[14:12] == 3'd5 && b >= a)) begin
            nxt = game_pkg::word_t'({w[31:25], w[11:7]});
          end
        end
        game_pkg::OPK_JMP: nxt = game_pkg::word_t'(w[31:7]);
        game_pkg::OPK_SPLI: exp_tab[game_pkg::slot_idx_t'(mreg[rd])][int'(w[35:33])*13 +: 13] =
          w[24:12];
        game_pkg::OPK_SPLREG:
          exp_tab[game_pkg::slot_idx_t'(mreg[w[16:12]])][int'(w[35:33])*13 +: 13] =
            mreg[rd][12:0];
        game_pkg::OPK_LISP: mreg[rd] = field_of(sa, w[35:33]);
        game_pkg::OPK_DIST: mreg[rd] = absd(field_of(sa, w[35:33]), field_of(sb, w[35:33])) +
                                       absd(field_of(sa, w[31:29]), field_of(sb, w[31:29]));
        default: begin
          done = 1'b1;  // unknown key halts
          count--;
        end
      endcase
      pc = nxt;
      if (pc >= INSTR_DEPTH) done = 1'b1;
    end
  endtask

  // top address down so the write at 0 restarts the core last
  task automatic load_prog(int total);
    for (int a = total; a >= 0; a--) begin
      prog_we = 1'b1;
      prog_addr = game_pkg::pc_t'(a);
      prog_data = prog[a];
      @(posedge pixel_clk_in);
      #1;
    end
    prog_we = 1'b0;
  endtask

  task automatic show_frame(int mid);
    new_frame = 1'b1;
    @(posedge pixel_clk_in);
    #1;
    new_frame = 1'b0;
    if (mid > 0) begin  // restart the scan partway through
      repeat (mid) @(posedge pixel_clk_in);
      #1;
      new_frame = 1'b1;
      @(posedge pixel_clk_in);
      #1;
      new_frame = 1'b0;
    end
    repeat (NUM_SPRITES * SLOT_CYCLES + 8) @(posedge pixel_clk_in);  // tail stays dark
    #1;
  endtask

  initial begin
    repeat (LIMIT) @(posedge pixel_clk_in);
    $display("timeout: run did not finish within %0d cycles", LIMIT);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    void'($urandom(32'h54da_1e9d));
    pixel_clk_in = 1'b0;
    rst_in = 1'b1;
    new_frame = 1'b0;
    prog_we = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    n_exec = 0;
    for (int s = 0; s < NUM_SPRITES; s++) exp_tab[s] = '0;
    for (int r = 0; r < game_pkg::NUM_REGS; r++) mreg[r] = '0;
    repeat (8) @(posedge pixel_clk_in);
    #1;
    rst_in = 1'b0;
    show_frame(0);  // empty table after reset
    for (int p = 0; p < NPROG; p++) begin
      gen_prog(p);
      run_model(n_exec);
      $display("program %0d: %0d instructions in model", p, n_exec);
      load_prog(PRE + BODY);
      wait (halted);
      @(posedge pixel_clk_in);
      #1;
      show_frame((p == NPROG - 1) ? 40 : 0);
    end
    $display("errors: %0d", chk_errors);
    if (chk_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
game_pkg.sv
instr_mem.sv
sprite_table.sv
game_alu.sv
game_core.sv
sprite_scanner.sv
game_top.sv
game_checker.sv
tb_game_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_game_top
RTL_TOP ?= game_top
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing -Wno-fatal

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^>>> PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
